// ==== ctrl_assertions.sv ====
////////////////////////////////////////
// bound to ctrl_top and sees its ports only
// the input rules are what the surrounding pipeline guarantees
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_assertions (
  input wire logic             clk,
  input wire logic             rst_n,
  input wire logic             branch_taken_ex_i,
  input wire logic             ext_req_i,
  input ctrl_pkg::dbg_in_t     dbg_i,
  input ctrl_pkg::pc_ctrl_t    pc_o,
  input ctrl_pkg::exc_ctrl_t   exc_o,
  input wire logic             dbg_ack_o
);

  // number of assertion failures so far
  int failures = 0;

  // EX resolves a branch once and the next cycle holds its target
  a_branch_single: assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else
    begin
      $error("taken branch high two cycles in a row");
      failures++;
    end

  // debug and interrupt requests stay exclusive
  a_req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(dbg_i.req && ext_req_i))
    else
    begin
      $error("debug and external request both high");
      failures++;
    end

  // jumping to the handler always acknowledges it
  a_exc_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_o.set && (pc_o.mux == ctrl_pkg::PC_EXCEPTION)) |-> exc_o.ack)
    else
    begin
      $error("exception pc set without acknowledge");
      failures++;
    end

  // debug acknowledge is a single cycle pulse
  a_dbg_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_ack_o |=> !dbg_ack_o)
    else
    begin
      $error("debug acknowledge high two cycles in a row");
      failures++;
    end

endmodule

bind ctrl_top ctrl_assertions i_assert (
  .clk (clk), .rst_n (rst_n), .branch_taken_ex_i (branch_taken_ex_i),
  .ext_req_i (ext_req_i), .dbg_i (dbg_i), .pc_o (pc_o), .exc_o (exc_o),
  .dbg_ack_o (dbg_ack_o)
);

`default_nettype wire

// ==== ctrl_defines.svh ====
////////////////////////////////////////
// encodings shared with fetch and ID stage muxes
// changing a code here changes the package enums too
////////////////////////////////////////
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// pc source select, consumed by the fetch stage
`define CTRL_PC_MUX_W      3
`define CTRL_PC_BOOT       3'b000
`define CTRL_PC_JUMP       3'b010
`define CTRL_PC_BRANCH     3'b011
`define CTRL_PC_EXCEPTION  3'b100
`define CTRL_PC_ERET       3'b101
`define CTRL_PC_DBG_NPC    3'b111

// operand forwarding mux select in ID
`define CTRL_FW_SEL_W      2
`define CTRL_SEL_REGFILE   2'b00
`define CTRL_SEL_FW_EX     2'b01
`define CTRL_SEL_FW_WB     2'b10

// jump kind as reported by the decoder
`define CTRL_JUMP_W        2
`define CTRL_BRANCH_NONE   2'b00
`define CTRL_BRANCH_JAL    2'b01
`define CTRL_BRANCH_JALR   2'b10
`define CTRL_BRANCH_COND   2'b11

`endif

// ==== ctrl_fsm.sv ====
////////////////////////////////////////
// jumps resolve in ID, branches in EX
// all outputs are combinational from state and inputs
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_fsm (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  fetch_enable_i,
  input  wire logic                  instr_valid_i,
  input  wire logic                  eret_insn_i,
  input  wire logic                  pipe_flush_i,
  input  wire logic                  branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e       jump_in_id_i,
  input  ctrl_pkg::jump_kind_e       jump_in_dec_i,
  input  wire logic                  exc_req_i,
  input  wire logic                  ext_req_i,
  input  wire logic                  data_load_event_i,
  input  wire logic                  id_ready_i,
  input  wire logic                  ex_valid_i,
  input  ctrl_pkg::dbg_in_t          dbg_i,
  input  wire logic                  jr_stall_i,
  output logic                       ctrl_busy_o,
  output logic                       is_decoding_o,
  output logic                       instr_req_o,
  output ctrl_pkg::pc_ctrl_t         pc_o,
  output ctrl_pkg::exc_ctrl_t        exc_o,
  output ctrl_pkg::halt_t            halt_o,
  output logic                       dbg_ack_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  // set once a jump or eret has redirected fetch for the ID instruction
  logic jump_done_q;
  logic jump_done;
  logic dec_is_jump;

  assign dec_is_jump = (jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
                       (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  ////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////
  always_comb
  begin
    state_d       = state_q;
    jump_done     = jump_done_q;
    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_o.set      = 1'b0;
    pc_o.mux      = ctrl_pkg::PC_BOOT;
    exc_o         = '0;
    halt_o        = '0;
    dbg_ack_o     = 1'b0;

    case (state_q)
      ctrl_pkg::RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // debug may enter before any fetch enable, npc is then unset
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
        else if (dbg_i.req)
          state_d = ctrl_pkg::DBG_SIGNAL;
      end

      ctrl_pkg::BOOT_SET:
      begin
        pc_o.set = 1'b1;
        pc_o.mux = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::SLEEP:
      begin
        ctrl_busy_o    = 1'b0;
        instr_req_o    = 1'b0;
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        // wake on fetch enable or a pending exception
        if (fetch_enable_i || exc_req_i)
          state_d = dbg_i.req ? ctrl_pkg::DBG_SIGNAL : ctrl_pkg::FIRST_FETCH;
        else if (dbg_i.req)
          state_d = ctrl_pkg::DBG_SIGNAL_SLEEP;
      end

      ctrl_pkg::FIRST_FETCH:
      begin
        // wait out the IF miss
        if (id_ready_i && !dbg_i.stall)
          state_d = ctrl_pkg::DECODE;
        // nothing is in ID yet so the IF pc is the one to save
        if (exc_req_i)
        begin
          pc_o.set      = 1'b1;
          pc_o.mux      = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack     = 1'b1;
          exc_o.save_if = 1'b1;
        end
      end

      ctrl_pkg::DECODE:
      begin
        // ID instruction counts only when no taken branch kills it
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;
          if (dec_is_jump)
          begin
            pc_o.mux = ctrl_pkg::PC_JUMP;
            // target is ready once the jr hazard is gone
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_o.set  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_o.set       = 1'b1;
            pc_o.mux       = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack      = 1'b1;
            exc_o.save_id  = 1'b1;
            // keep the faulting instruction out of EX
            halt_o.halt_id = 1'b1;
          end

          if (eret_insn_i)
          begin
            pc_o.mux         = ctrl_pkg::PC_ERET;
            exc_o.restore_id = 1'b1;
            if (!jump_done_q)
            begin
              pc_o.set  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // wfi, or eret back into sleep, drains EX and WB first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_o.halt_if = 1'b1;
            halt_o.halt_id = 1'b1;
            state_d        = ctrl_pkg::FLUSH_EX;
          end
          else if (dbg_i.req)
          begin
            halt_o.halt_if = 1'b1;
            // leave only once the ID instruction has moved on
            if (id_ready_i)
            begin
              if (jump_in_id_i == ctrl_pkg::BRANCH_COND)
                state_d = ctrl_pkg::DBG_WAIT_BRANCH;
              else
                state_d = ctrl_pkg::DBG_SIGNAL;
            end
            // p.elw blocks ID, debug still enters
            else if (data_load_event_i)
              state_d = ctrl_pkg::DBG_SIGNAL;
          end
        end

        // interrupt with an empty ID stage
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i)
        begin
          pc_o.set       = 1'b1;
          pc_o.mux       = ctrl_pkg::PC_EXCEPTION;
          exc_o.ack      = 1'b1;
          exc_o.save_if  = 1'b1;
          halt_o.halt_id = 1'b1;
        end

        if (branch_taken_ex_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_BRANCH;
          // interrupt returns to the branch target
          if (ext_req_i)
          begin
            pc_o.mux               = ctrl_pkg::PC_EXCEPTION;
            exc_o.ack              = 1'b1;
            exc_o.save_takenbranch = 1'b1;
            halt_o.halt_id         = 1'b1;
          end
          if (dbg_i.req)
            state_d = ctrl_pkg::DBG_SIGNAL;
        end
      end

      ctrl_pkg::FLUSH_EX:
      begin
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      ctrl_pkg::FLUSH_WB:
      begin
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (fetch_enable_i)
        begin
          if (dbg_i.req)
            state_d = ctrl_pkg::DBG_SIGNAL;
          else
          begin
            state_d        = ctrl_pkg::DECODE;
            halt_o.halt_if = 1'b0;
          end
        end
        else
          state_d = dbg_i.req ? ctrl_pkg::DBG_SIGNAL_SLEEP : ctrl_pkg::SLEEP;
      end

      // branch in ID at debug entry, apply it before signalling
      ctrl_pkg::DBG_WAIT_BRANCH:
      begin
        halt_o.halt_if = 1'b1;
        if (branch_taken_ex_i)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_BRANCH;
        end
        state_d = ctrl_pkg::DBG_SIGNAL;
      end

      ctrl_pkg::DBG_SIGNAL,
      ctrl_pkg::DBG_SIGNAL_SLEEP:
      begin
        dbg_ack_o      = 1'b1;
        halt_o.halt_if = 1'b1;
        if (state_q == ctrl_pkg::DBG_SIGNAL)
          state_d = ctrl_pkg::DBG_WAIT;
        else
          state_d = ctrl_pkg::DBG_WAIT_SLEEP;
      end

      // debugger owns the core here
      ctrl_pkg::DBG_WAIT,
      ctrl_pkg::DBG_WAIT_SLEEP:
      begin
        halt_o.halt_if = 1'b1;
        if (dbg_i.jump_req)
        begin
          pc_o.set = 1'b1;
          pc_o.mux = ctrl_pkg::PC_DBG_NPC;
        end
        if (!dbg_i.stall)
        begin
          if (state_q == ctrl_pkg::DBG_WAIT)
            state_d = ctrl_pkg::DECODE;
          else
            state_d = ctrl_pkg::SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once ID accepts the next instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
////////////////////////////////////////
// controller types, codes come from the defines header
////////////////////////////////////////
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET, BOOT_SET, SLEEP, FIRST_FETCH,
    DECODE, FLUSH_EX, FLUSH_WB,
    DBG_SIGNAL, DBG_SIGNAL_SLEEP, DBG_WAIT, DBG_WAIT_BRANCH, DBG_WAIT_SLEEP
  } ctrl_state_e;

  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = `CTRL_PC_BOOT,
    PC_JUMP      = `CTRL_PC_JUMP,
    PC_BRANCH    = `CTRL_PC_BRANCH,
    PC_EXCEPTION = `CTRL_PC_EXCEPTION,
    PC_ERET      = `CTRL_PC_ERET,
    PC_DBG_NPC   = `CTRL_PC_DBG_NPC
  } pc_mux_e;

  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = `CTRL_SEL_REGFILE,
    SEL_FW_EX   = `CTRL_SEL_FW_EX,
    SEL_FW_WB   = `CTRL_SEL_FW_WB
  } fw_sel_e;

  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BRANCH_NONE = `CTRL_BRANCH_NONE,
    BRANCH_JAL  = `CTRL_BRANCH_JAL,
    BRANCH_JALR = `CTRL_BRANCH_JALR,
    BRANCH_COND = `CTRL_BRANCH_COND
  } jump_kind_e;

  // pc update request towards the fetch stage
  typedef struct packed {
    logic    set;
    pc_mux_e mux;
  } pc_ctrl_t;

  // exception controller handshake strobes
  typedef struct packed {
    logic ack;
    logic save_if;
    logic save_id;
    logic save_takenbranch;
    logic restore_id;
  } exc_ctrl_t;

  typedef struct packed {
    logic halt_if;
    logic halt_id;
  } halt_t;

  // from the debug unit
  typedef struct packed {
    logic req;
    logic stall;
    logic jump_req;
  } dbg_in_t;

  // write enables and register match flags from the pipeline
  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic alu_we_fw;
    logic wb_is_a;
    logic wb_is_b;
    logic alu_is_a;
    logic alu_is_b;
  } wb_hazard_t;

  typedef struct packed {
    fw_sel_e a;
    fw_sel_e b;
  } fw_sel_t;

endpackage

`default_nettype wire

// ==== ctrl_top.sv ====
////////////////////////////////////////
// main controller, separate ID and EX stages
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  fetch_enable_i,
  input  wire logic                  instr_valid_i,
  input  wire logic                  illegal_insn_i,
  input  wire logic                  eret_insn_i,
  input  wire logic                  pipe_flush_i,
  input  wire logic                  data_req_ex_i,
  input  wire logic                  data_load_event_i,
  input  wire logic                  branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e       jump_in_id_i,
  input  ctrl_pkg::jump_kind_e       jump_in_dec_i,
  input  wire logic                  exc_req_i,
  input  wire logic                  ext_req_i,
  input  ctrl_pkg::dbg_in_t          dbg_i,
  input  ctrl_pkg::wb_hazard_t       haz_i,
  input  wire logic                  id_ready_i,
  input  wire logic                  ex_valid_i,
  output logic                       ctrl_busy_o,
  output logic                       is_decoding_o,
  output logic                       instr_req_o,
  output ctrl_pkg::pc_ctrl_t         pc_o,
  output ctrl_pkg::exc_ctrl_t        exc_o,
  output ctrl_pkg::halt_t            halt_o,
  output logic                       dbg_ack_o,
  output logic                       deassert_we_o,
  output logic                       load_stall_o,
  output logic                       jr_stall_o,
  output ctrl_pkg::fw_sel_t          fw_o
);

  // is_decoding_o and jr_stall_o also close the loop between FSM and hazards
  ctrl_fsm i_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jump_in_id_i      (jump_in_id_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .exc_req_i         (exc_req_i),
    .ext_req_i         (ext_req_i),
    .data_load_event_i (data_load_event_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .dbg_i             (dbg_i),
    .jr_stall_i        (jr_stall_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .pc_o              (pc_o),
    .exc_o             (exc_o),
    .halt_o            (halt_o),
    .dbg_ack_o         (dbg_ack_o)
  );

  hazard_stall i_hazard (
    .data_req_ex_i  (data_req_ex_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .haz_i          (haz_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding_o),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  operand_fwd i_fwd (
    .haz_i (haz_i),
    .fw_o  (fw_o)
  );

endmodule

`default_nettype wire

// ==== hazard_stall.sv ====
////////////////////////////////////////
// two-port register file, no operand c
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module hazard_stall (
  input  wire logic              data_req_ex_i,
  input  ctrl_pkg::jump_kind_e   jump_in_dec_i,
  input  ctrl_pkg::wb_hazard_t   haz_i,
  input  wire logic              illegal_insn_i,
  input  wire logic              is_decoding_i,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   deassert_we_o
);

  always_comb
  begin
    load_stall_o  = 1'b0;
    jr_stall_o    = 1'b0;
    // no write back for instructions that are not really decoded
    deassert_we_o = !is_decoding_i || illegal_insn_i;

    // load in EX feeds an operand of the ID instruction
    if (data_req_ex_i && haz_i.we_ex && (haz_i.alu_is_a || haz_i.alu_is_b))
    begin
      load_stall_o  = 1'b1;
      deassert_we_o = 1'b1;
    end

    // jalr target register still in flight
    // the pc adder has no forward path so any match stalls
    if ((jump_in_dec_i == ctrl_pkg::BRANCH_JALR) &&
        ((haz_i.we_wb && haz_i.wb_is_a) ||
         (haz_i.we_ex && haz_i.alu_is_a) ||
         (haz_i.alu_we_fw && haz_i.alu_is_a)))
    begin
      jr_stall_o    = 1'b1;
      deassert_we_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== operand_fwd.sv ====
////////////////////////////////////////
// EX result wins over WB on a double match
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module operand_fwd (
  input  ctrl_pkg::wb_hazard_t haz_i,
  output ctrl_pkg::fw_sel_t    fw_o
);

  always_comb
  begin
    fw_o.a = ctrl_pkg::SEL_REGFILE;
    fw_o.b = ctrl_pkg::SEL_REGFILE;

    // WB to ID
    if (haz_i.we_wb)
    begin
      if (haz_i.wb_is_a)
        fw_o.a = ctrl_pkg::SEL_FW_WB;
      if (haz_i.wb_is_b)
        fw_o.b = ctrl_pkg::SEL_FW_WB;
    end

    // EX to ID, newer value so it overrides
    if (haz_i.alu_we_fw)
    begin
      if (haz_i.alu_is_a)
        fw_o.a = ctrl_pkg::SEL_FW_EX;
      if (haz_i.alu_is_b)
        fw_o.b = ctrl_pkg::SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the controller testbench with Verilator and run it
# pass or fail comes from the result line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module tb_ctrl \
  -f sources.f -o sim_ctrl \
  && ./obj_dir/sim_ctrl | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+.
ctrl_pkg.sv
ctrl_fsm.sv
hazard_stall.sv
operand_fwd.sv
ctrl_top.sv
ctrl_assertions.sv
tb_ctrl.sv

// ==== tb_ctrl.sv ====
////////////////////////////////////////
// rows run back to back so FSM state carries over
// inputs move 1 ns after the edge and outputs are sampled 1 ns before the next
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_ctrl;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 10;

  // stimulus columns msb first
  typedef struct packed {
    logic [4:0] ctl;   // fetch_en instr_valid illegal eret pipe_flush
    logic [2:0] ex;    // data_req_ex load_event branch_taken
    logic [3:0] jump;  // jump_in_id jump_in_dec
    logic [1:0] exc;   // exc_req ext_req
    logic [2:0] dbg;   // req stall jump_req
    logic [6:0] haz;   // we_ex we_wb alu_we_fw wb_is_a wb_is_b alu_is_a alu_is_b
    logic [1:0] rdy;   // id_ready ex_valid
  } stim_t;

  // expected columns msb first
  typedef struct packed {
    logic [3:0] pc;    // set bit then source, which reads 000 when not set
    logic [4:0] exc;   // ack save_if save_id save_takenbranch restore_id
    logic [1:0] halt;  // halt_if halt_id
    logic [3:0] sts;   // dbg_ack is_decoding busy instr_req
    logic [2:0] stl;   // load_stall jr_stall deassert_we
    logic [3:0] fw;    // operand a then operand b
  } expect_t;

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_enable, instr_valid, illegal_insn, eret_insn, pipe_flush;
  logic data_req_ex, data_load_event, branch_taken_ex;
  logic exc_req, ext_req, id_ready, ex_valid;
  ctrl_pkg::jump_kind_e   jump_in_id;
  ctrl_pkg::jump_kind_e   jump_in_dec;
  ctrl_pkg::dbg_in_t      dbg;
  ctrl_pkg::wb_hazard_t   haz;
  logic ctrl_busy, is_decoding, instr_req, dbg_ack;
  logic deassert_we, load_stall, jr_stall;
  ctrl_pkg::pc_ctrl_t     pc;
  ctrl_pkg::exc_ctrl_t    exc;
  ctrl_pkg::halt_t        halt;
  ctrl_pkg::fw_sel_t      fw;

  string   name_q[$];
  stim_t   stim_q[$];
  expect_t exp_q[$];
  int      errors = 0;
  int      checks = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ctrl_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .instr_valid_i (instr_valid),
    .illegal_insn_i (illegal_insn), .eret_insn_i (eret_insn),
    .pipe_flush_i (pipe_flush), .data_req_ex_i (data_req_ex),
    .data_load_event_i (data_load_event), .branch_taken_ex_i (branch_taken_ex),
    .jump_in_id_i (jump_in_id), .jump_in_dec_i (jump_in_dec),
    .exc_req_i (exc_req), .ext_req_i (ext_req), .dbg_i (dbg), .haz_i (haz),
    .id_ready_i (id_ready), .ex_valid_i (ex_valid),
    .ctrl_busy_o (ctrl_busy), .is_decoding_o (is_decoding), .instr_req_o (instr_req),
    .pc_o (pc), .exc_o (exc), .halt_o (halt), .dbg_ack_o (dbg_ack),
    .deassert_we_o (deassert_we), .load_stall_o (load_stall),
    .jr_stall_o (jr_stall), .fw_o (fw)
  );

  task automatic add_row(input string name, input stim_t s, input expect_t e);
    name_q.push_back(name);
    stim_q.push_back(s);
    exp_q.push_back(e);
  endtask

  // id jump kind and load event only matter while debug is requested
  task automatic apply_stim(input stim_t s);
    logic [31:0] rnd;
    rnd             = $urandom();
    fetch_enable    = s.ctl[4];
    instr_valid     = s.ctl[3];
    illegal_insn    = s.ctl[2];
    eret_insn       = s.ctl[1];
    pipe_flush      = s.ctl[0];
    data_req_ex     = s.ex[2];
    data_load_event = s.ex[1];
    branch_taken_ex = s.ex[0];
    jump_in_id      = ctrl_pkg::jump_kind_e'(s.jump[3:2]);
    jump_in_dec     = ctrl_pkg::jump_kind_e'(s.jump[1:0]);
    exc_req         = s.exc[1];
    ext_req         = s.exc[0];
    dbg             = s.dbg;
    haz             = s.haz;
    id_ready        = s.rdy[1];
    ex_valid        = s.rdy[0];
    if (!s.dbg[2])
    begin
      jump_in_id      = ctrl_pkg::jump_kind_e'(rnd[1:0]);
      data_load_event = rnd[2];
    end
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
    end
  endtask

  task automatic check_row(input string test, input expect_t e);
    check_value(test, "pc", 32'(e.pc), 32'(pc.set ? {1'b1, pc.mux} : 4'b0000));
    check_value(test, "exc", 32'(e.exc), 32'(exc));
    check_value(test, "halt", 32'(e.halt), 32'(halt));
    check_value(test, "status", 32'(e.sts), 32'({dbg_ack, is_decoding, ctrl_busy, instr_req}));
    check_value(test, "stall", 32'(e.stl), 32'({load_stall, jr_stall, deassert_we}));
    check_value(test, "fwd", 32'(e.fw), 32'(fw));
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////
  task automatic build_table();
    // ctl   ex  jump exc dbg haz     rdy    pc   exc   ht sts  stl fw
    add_row("rst_idle",   26'b00000_000_0000_00_000_0000000_00, 22'b0000_00000_00_0000_001_0000);
    add_row("rst_fetch",  26'b10000_000_0000_00_000_0000000_00, 22'b0000_00000_00_0000_001_0000);
    add_row("boot_set",   26'b10000_000_0000_00_000_0000000_00, 22'b1000_00000_00_0011_001_0000);
    add_row("ff_wait",    26'b10000_000_0000_00_000_0000000_00, 22'b0000_00000_00_0011_001_0000);
    add_row("ff_go",      26'b10000_000_0000_00_000_0000000_10, 22'b0000_00000_00_0011_001_0000);
    add_row("dec_alu",    26'b11000_000_0000_00_000_0000000_10, 22'b0000_00000_00_0111_000_0000);
    // jal redirects once until ID accepts the next instruction
    add_row("jal",        26'b11000_000_0001_00_000_0000000_00, 22'b1010_00000_00_0111_000_0000);
    add_row("jal_hold",   26'b11000_000_0001_00_000_0000000_00, 22'b0000_00000_00_0111_000_0000);
    add_row("jal_rel",    26'b11000_000_0001_00_000_0000000_10, 22'b0000_00000_00_0111_000_0000);
    add_row("jal_again",  26'b11000_000_0001_00_000_0000000_10, 22'b1010_00000_00_0111_000_0000);
    add_row("jalr_stall", 26'b11000_000_0010_00_000_0101000_10, 22'b0000_00000_00_0111_011_1000);
    add_row("br_taken",   26'b11000_001_0000_00_000_0000000_10, 22'b1011_00000_00_0011_001_0000);
    add_row("dec_alu2",   26'b11000_000_0000_00_000_0000000_10, 22'b0000_00000_00_0111_000_0000);
    add_row("br_irq",     26'b11000_001_0000_01_000_0000000_10, 22'b1100_10010_01_0011_001_0000);
    add_row("exc_alu",    26'b11000_000_0000_10_000_0000000_10, 22'b1100_10100_01_0111_000_0000);
    add_row("eret",       26'b11010_000_0000_00_000_0000000_10, 22'b1101_00001_00_0111_000_0000);
    // hazards and forwarding
    add_row("load_use",   26'b11000_100_0000_00_000_1000010_10, 22'b0000_00000_00_0111_101_0000);
    add_row("fwd_both",   26'b11000_000_0000_00_000_0111110_10, 22'b0000_00000_00_0111_000_0110);
    add_row("fwd_wb",     26'b11000_000_0000_00_000_0101100_10, 22'b0000_00000_00_0111_000_1010);
    add_row("illegal",    26'b11100_000_0000_00_000_0000000_10, 22'b0000_00000_00_0111_001_0000);
    // debug entry then npc jump then resume
    add_row("dbg_req",    26'b11000_000_0000_00_110_0000000_10, 22'b0000_00000_10_0111_000_0000);
    add_row("dbg_ack",    26'b11000_000_0000_00_110_0000000_10, 22'b0000_00000_10_1011_001_0000);
    add_row("dbg_wait",   26'b11000_000_0000_00_010_0000000_10, 22'b0000_00000_10_0011_001_0000);
    add_row("dbg_jump",   26'b11000_000_0000_00_011_0000000_10, 22'b1111_00000_10_0011_001_0000);
    add_row("dbg_resume", 26'b11000_000_0000_00_000_0000000_10, 22'b0000_00000_10_0011_001_0000);
    add_row("dec_resume", 26'b11000_000_0000_00_000_0000000_10, 22'b0000_00000_00_0111_000_0000);
    // wfi drains into sleep and an exception wakes it
    add_row("wfi_flush",  26'b11001_000_0000_00_000_0000000_10, 22'b0000_00000_11_0111_000_0000);
    add_row("flush_wait", 26'b00000_000_0000_00_000_0000000_00, 22'b0000_00000_11_0011_001_0000);
    add_row("flush_done", 26'b00000_000_0000_00_000_0000000_01, 22'b0000_00000_11_0011_001_0000);
    add_row("flush_wb",   26'b00000_000_0000_00_000_0000000_00, 22'b0000_00000_11_0011_001_0000);
    add_row("sleep",      26'b00000_000_0000_00_000_0000000_00, 22'b0000_00000_11_0000_001_0000);
    add_row("sleep_wake", 26'b00000_000_0000_10_000_0000000_00, 22'b0000_00000_11_0000_001_0000);
    add_row("ff_exc",     26'b00000_000_0000_10_000_0000000_00, 22'b1100_11000_00_0011_001_0000);
  endtask

  initial
  begin
    void'($urandom(32'hb141defa));
    build_table();
    apply_stim('0);
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < name_q.size(); i++)
    begin
      @(posedge clk);
      #1;
      apply_stim(stim_q[i]);
      #(CLK_PERIOD - 2);
      check_row(name_q[i], exp_q[i]);
    end
    errors += i_dut.i_assert.failures;
    $display("rows %0d checks %0d errors %0d", name_q.size(), checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // limit scales with the table length and the margin covers reset
  initial
  begin
    #1;
    #((name_q.size() + 20) * CLK_PERIOD);
    $display("timeout: the stimulus table did not finish within the time limit");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
